/* soc_bus_consts.svh */
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// memory window behind the external port.
`define SOC_MEM_BASE 32'h8000_0000
`define SOC_MEM_WORDS 1024

// mtime words of the clint, read only.
`define SOC_MTIME_LO 32'h0200_0048
`define SOC_MTIME_HI 32'h0200_004c

`endif

/* source/soc_bus_pkg.sv */
package soc_bus_pkg;

  // encodings follow the AXI response field.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } bus_resp_t;

  // current bus owner.
  typedef enum logic [1:0] {
    MASTER_NONE  = 2'd0,
    MASTER_FETCH = 2'd1,
    MASTER_LSU   = 2'd2
  } bus_master_t;

  // where the granted transfer is routed.
  typedef enum logic [1:0] {
    TARGET_NONE     = 2'd0,
    TARGET_CLINT    = 2'd1,
    TARGET_EXTERNAL = 2'd2
  } bus_target_t;

endpackage

/* source/clint.sv */
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module clint (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output soc_bus_pkg::bus_resp_t rresp,
  output logic                   rvalid,
  input  logic                   rready
);

  logic [63:0] mtime;
  logic        ar_fire;

  assign arready = !rvalid; // one read in flight.
  assign ar_fire = arvalid & arready;

  // free running since reset.
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= 64'h0;
    end else begin
      mtime <= mtime + 64'h1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  // half of mtime captured at address accept.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      if (araddr == `SOC_MTIME_LO) begin
        rdata <= mtime[31:0];
        rresp <= soc_bus_pkg::RESP_OKAY;
      end else if (araddr == `SOC_MTIME_HI) begin
        rdata <= mtime[63:32];
        rresp <= soc_bus_pkg::RESP_OKAY;
      end else begin
        rdata <= 32'h0;
        rresp <= soc_bus_pkg::RESP_SLVERR;
      end
    end
  end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module bus_arbiter (
  input  logic                   clock,
  input  logic                   reset,

  // fetch port, read only.
  input  logic [31:0]            araddr_0,
  input  logic                   arvalid_0,
  output logic                   arready_0,
  output logic [31:0]            rdata_0,
  output soc_bus_pkg::bus_resp_t rresp_0,
  output logic                   rvalid_0,
  input  logic                   rready_0,

  // load/store port.
  input  logic [31:0]            araddr_1,
  input  logic                   arvalid_1,
  output logic                   arready_1,
  output logic [31:0]            rdata_1,
  output soc_bus_pkg::bus_resp_t rresp_1,
  output logic                   rvalid_1,
  input  logic                   rready_1,
  input  logic [31:0]            awaddr_1,
  input  logic                   awvalid_1,
  output logic                   awready_1,
  input  logic [31:0]            wdata_1,
  input  logic [3:0]             wstrb_1,
  input  logic                   wvalid_1,
  output logic                   wready_1,
  output soc_bus_pkg::bus_resp_t bresp_1,
  output logic                   bvalid_1,
  input  logic                   bready_1,

  // external slave port.
  output logic [31:0]            io_master_araddr,
  output logic                   io_master_arvalid,
  input  logic                   io_master_arready,
  input  logic [31:0]            io_master_rdata,
  input  soc_bus_pkg::bus_resp_t io_master_rresp,
  input  logic                   io_master_rvalid,
  output logic                   io_master_rready,
  output logic [31:0]            io_master_awaddr,
  output logic                   io_master_awvalid,
  input  logic                   io_master_awready,
  output logic [31:0]            io_master_wdata,
  output logic [3:0]             io_master_wstrb,
  output logic                   io_master_wvalid,
  input  logic                   io_master_wready,
  input  soc_bus_pkg::bus_resp_t io_master_bresp,
  input  logic                   io_master_bvalid,
  output logic                   io_master_bready
);

  soc_bus_pkg::bus_master_t owner;
  soc_bus_pkg::bus_target_t target;
  logic                     grant_write; // lsu grant is a write.

  logic mtime_hit;
  logic fetch_rd;
  logic lsu_rd;
  logic lsu_wr;
  logic ext_rd;
  logic clint_rd;
  logic grant_done;

  logic [31:0]            clint_araddr;
  logic                   clint_arvalid;
  logic                   clint_arready;
  logic [31:0]            clint_rdata;
  soc_bus_pkg::bus_resp_t clint_rresp;
  logic                   clint_rvalid;
  logic                   clint_rready;

  // read channel of the granted master and of the routed slave.
  logic [31:0]            rd_araddr;
  logic                   rd_arvalid;
  logic                   rd_rready;
  logic                   rd_arready;
  logic [31:0]            rd_rdata;
  soc_bus_pkg::bus_resp_t rd_rresp;
  logic                   rd_rvalid;

  assign mtime_hit = (araddr_1 == `SOC_MTIME_LO) || (araddr_1 == `SOC_MTIME_HI);

  assign fetch_rd = (owner == soc_bus_pkg::MASTER_FETCH);
  assign lsu_rd   = (owner == soc_bus_pkg::MASTER_LSU) && !grant_write;
  assign lsu_wr   = (owner == soc_bus_pkg::MASTER_LSU) && grant_write &&
                    (target == soc_bus_pkg::TARGET_EXTERNAL);
  assign ext_rd   = (fetch_rd || lsu_rd) && (target == soc_bus_pkg::TARGET_EXTERNAL);
  assign clint_rd = lsu_rd && (target == soc_bus_pkg::TARGET_CLINT);

  // request side, master to slave.
  assign rd_araddr  = lsu_rd ? araddr_1 : araddr_0;
  assign rd_arvalid = (fetch_rd & arvalid_0) | (lsu_rd & arvalid_1);
  assign rd_rready  = (fetch_rd & rready_0) | (lsu_rd & rready_1);

  assign io_master_araddr  = ext_rd ? rd_araddr : 32'h0;
  assign io_master_arvalid = ext_rd & rd_arvalid;
  assign io_master_rready  = ext_rd & rd_rready;

  assign clint_araddr  = clint_rd ? araddr_1 : 32'h0;
  assign clint_arvalid = clint_rd & arvalid_1;
  assign clint_rready  = clint_rd & rready_1;

  // response side, slave to master.
  assign rd_arready = clint_rd ? clint_arready : (ext_rd & io_master_arready);
  assign rd_rvalid  = clint_rd ? clint_rvalid : (ext_rd & io_master_rvalid);
  assign rd_rdata   = clint_rd ? clint_rdata : (ext_rd ? io_master_rdata : 32'h0);
  assign rd_rresp   = clint_rd ? clint_rresp :
                      (ext_rd ? io_master_rresp : soc_bus_pkg::RESP_OKAY);

  assign arready_0 = fetch_rd & rd_arready;
  assign rvalid_0  = fetch_rd & rd_rvalid;
  assign rdata_0   = fetch_rd ? rd_rdata : 32'h0;
  assign rresp_0   = fetch_rd ? rd_rresp : soc_bus_pkg::RESP_OKAY;

  assign arready_1 = lsu_rd & rd_arready;
  assign rvalid_1  = lsu_rd & rd_rvalid;
  assign rdata_1   = lsu_rd ? rd_rdata : 32'h0;
  assign rresp_1   = lsu_rd ? rd_rresp : soc_bus_pkg::RESP_OKAY;

  // write path only ever goes external.
  assign io_master_awaddr  = lsu_wr ? awaddr_1 : 32'h0;
  assign io_master_awvalid = lsu_wr & awvalid_1;
  assign io_master_wdata   = lsu_wr ? wdata_1 : 32'h0;
  assign io_master_wstrb   = lsu_wr ? wstrb_1 : 4'h0;
  assign io_master_wvalid  = lsu_wr & wvalid_1;
  assign io_master_bready  = lsu_wr & bready_1;

  assign awready_1 = lsu_wr & io_master_awready;
  assign wready_1  = lsu_wr & io_master_wready;
  assign bvalid_1  = lsu_wr & io_master_bvalid;
  assign bresp_1   = lsu_wr ? io_master_bresp : soc_bus_pkg::RESP_OKAY;

  // grant ends on the response handshake, so a stalled master keeps it.
  assign grant_done = (rd_rvalid & rd_rready) | (io_master_bvalid & io_master_bready);

  always_ff @(posedge clock) begin
    if (reset) begin
      owner       <= soc_bus_pkg::MASTER_NONE;
      target      <= soc_bus_pkg::TARGET_NONE;
      grant_write <= 1'b0;
    end else if (owner == soc_bus_pkg::MASTER_NONE) begin
      if (arvalid_0) begin // fetch first.
        owner       <= soc_bus_pkg::MASTER_FETCH;
        target      <= soc_bus_pkg::TARGET_EXTERNAL;
        grant_write <= 1'b0;
      end else if (arvalid_1) begin
        owner       <= soc_bus_pkg::MASTER_LSU;
        target      <= mtime_hit ? soc_bus_pkg::TARGET_CLINT : soc_bus_pkg::TARGET_EXTERNAL;
        grant_write <= 1'b0;
      end else if (awvalid_1) begin
        owner       <= soc_bus_pkg::MASTER_LSU;
        target      <= soc_bus_pkg::TARGET_EXTERNAL;
        grant_write <= 1'b1;
      end
    end else if (grant_done) begin
      owner       <= soc_bus_pkg::MASTER_NONE;
      target      <= soc_bus_pkg::TARGET_NONE;
      grant_write <= 1'b0;
    end
  end

  clint clint_i (
    .clock   (clock),
    .reset   (reset),
    .araddr  (clint_araddr),
    .arvalid (clint_arvalid),
    .arready (clint_arready),
    .rdata   (clint_rdata),
    .rresp   (clint_rresp),
    .rvalid  (clint_rvalid),
    .rready  (clint_rready)
  );

endmodule

/* source/sram_slave.sv */
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module sram_slave (
  input  logic                   clock,
  input  logic                   reset,

  input  logic [31:0]            araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output soc_bus_pkg::bus_resp_t rresp,
  output logic                   rvalid,
  input  logic                   rready,

  input  logic [31:0]            awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output soc_bus_pkg::bus_resp_t bresp,
  output logic                   bvalid,
  input  logic                   bready
);

  localparam int          INDEX_BITS = $clog2(`SOC_MEM_WORDS);
  localparam logic [31:0] MEM_BYTES  = `SOC_MEM_WORDS * 4;

  logic [31:0] mem [`SOC_MEM_WORDS];

  logic [31:0]           rd_offset;
  logic [31:0]           wr_offset;
  logic                  rd_hit;
  logic                  wr_hit;
  logic [INDEX_BITS-1:0] rd_index;
  logic [INDEX_BITS-1:0] wr_index;
  logic                  ar_fire;
  logic                  w_fire;

  // below the base wraps to a large offset, so one compare covers both ends.
  assign rd_offset = araddr - `SOC_MEM_BASE;
  assign wr_offset = awaddr - `SOC_MEM_BASE;
  assign rd_hit    = rd_offset < MEM_BYTES;
  assign wr_hit    = wr_offset < MEM_BYTES;
  assign rd_index  = rd_offset[INDEX_BITS+1:2];
  assign wr_index  = wr_offset[INDEX_BITS+1:2];

  assign arready = !rvalid;
  assign ar_fire = arvalid & arready;

  // address and data are taken in the same cycle.
  assign awready = !bvalid;
  assign wready  = awready;
  assign w_fire  = awvalid & wvalid & awready;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (w_fire) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= rd_hit ? mem[rd_index] : 32'h0;
      rresp <= rd_hit ? soc_bus_pkg::RESP_OKAY : soc_bus_pkg::RESP_DECERR;
    end
  end

  always_ff @(posedge clock) begin
    if (w_fire) begin
      bresp <= wr_hit ? soc_bus_pkg::RESP_OKAY : soc_bus_pkg::RESP_DECERR;
    end
  end

  // byte merge under wstrb.
  always_ff @(posedge clock) begin
    if (w_fire && wr_hit) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[wr_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

/* source/soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top (
  input  logic                   clock,
  input  logic                   reset,

  input  logic [31:0]            araddr_0,
  input  logic                   arvalid_0,
  output logic                   arready_0,
  output logic [31:0]            rdata_0,
  output soc_bus_pkg::bus_resp_t rresp_0,
  output logic                   rvalid_0,
  input  logic                   rready_0,

  input  logic [31:0]            araddr_1,
  input  logic                   arvalid_1,
  output logic                   arready_1,
  output logic [31:0]            rdata_1,
  output soc_bus_pkg::bus_resp_t rresp_1,
  output logic                   rvalid_1,
  input  logic                   rready_1,
  input  logic [31:0]            awaddr_1,
  input  logic                   awvalid_1,
  output logic                   awready_1,
  input  logic [31:0]            wdata_1,
  input  logic [3:0]             wstrb_1,
  input  logic                   wvalid_1,
  output logic                   wready_1,
  output soc_bus_pkg::bus_resp_t bresp_1,
  output logic                   bvalid_1,
  input  logic                   bready_1
);

  logic [31:0]            io_master_araddr;
  logic                   io_master_arvalid;
  logic                   io_master_arready;
  logic [31:0]            io_master_rdata;
  soc_bus_pkg::bus_resp_t io_master_rresp;
  logic                   io_master_rvalid;
  logic                   io_master_rready;
  logic [31:0]            io_master_awaddr;
  logic                   io_master_awvalid;
  logic                   io_master_awready;
  logic [31:0]            io_master_wdata;
  logic [3:0]             io_master_wstrb;
  logic                   io_master_wvalid;
  logic                   io_master_wready;
  soc_bus_pkg::bus_resp_t io_master_bresp;
  logic                   io_master_bvalid;
  logic                   io_master_bready;

  bus_arbiter bus_arbiter_i (.*);

  sram_slave sram_slave_i (
    .clock   (clock),
    .reset   (reset),
    .araddr  (io_master_araddr),
    .arvalid (io_master_arvalid),
    .arready (io_master_arready),
    .rdata   (io_master_rdata),
    .rresp   (io_master_rresp),
    .rvalid  (io_master_rvalid),
    .rready  (io_master_rready),
    .awaddr  (io_master_awaddr),
    .awvalid (io_master_awvalid),
    .awready (io_master_awready),
    .wdata   (io_master_wdata),
    .wstrb   (io_master_wstrb),
    .wvalid  (io_master_wvalid),
    .wready  (io_master_wready),
    .bresp   (io_master_bresp),
    .bvalid  (io_master_bvalid),
    .bready  (io_master_bready)
  );

endmodule

/* tb/soc_bus_checker.sv */
`timescale 1ns/10ps

module soc_bus_checker (
  input logic                   clock,
  input logic                   reset,
  input logic                   arvalid_0,
  input logic                   arready_0,
  input logic [31:0]            rdata_0,
  input soc_bus_pkg::bus_resp_t rresp_0,
  input logic                   rvalid_0,
  input logic                   rready_0,
  input logic                   arvalid_1,
  input logic                   arready_1,
  input logic [31:0]            rdata_1,
  input soc_bus_pkg::bus_resp_t rresp_1,
  input logic                   rvalid_1,
  input logic                   rready_1,
  input logic                   awvalid_1,
  input logic                   awready_1,
  input logic                   wready_1,
  input logic                   bvalid_1
);

  logic seen_request;

  always_ff @(posedge clock) begin
    if (reset) begin
      seen_request <= 1'b0;
    end else if (arvalid_0 || arvalid_1 || awvalid_1) begin
      seen_request <= 1'b1;
    end
  end

  r0_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid_0 && !rready_0 |=> rvalid_0 && $stable(rdata_0) && $stable(rresp_0))
    else $error("rvalid_0 dropped or its data changed before rready_0");

  r1_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid_1 && !rready_1 |=> rvalid_1 && $stable(rdata_1) && $stable(rresp_1))
    else $error("rvalid_1 dropped or its data changed before rready_1");

  ar_one_hot: assert property (@(posedge clock) disable iff (reset)
    !(arready_0 && arready_1))
    else $error("arready_0 and arready_1 high together");

  // quiet bus until the first request.
  idle_quiet: assert property (@(posedge clock) disable iff (reset)
    !seen_request |-> !(arready_0 || arready_1 || rvalid_0 || rvalid_1 ||
                        awready_1 || wready_1 || bvalid_1))
    else $error("valid or ready output high before any request");

endmodule

bind soc_bus_top soc_bus_checker soc_bus_checker_i (.*);

/* tb/soc_bus_tb.sv */
`timescale 1ns/10ps
`include "soc_bus_consts.svh"

module soc_bus_tb;

  localparam int          N_FILL       = 8;
  localparam int          N_MERGE      = 4;
  localparam int          N_TRANS      = 2 * N_FILL + 3 * N_MERGE + 3 + 4 + 3;
  localparam int          RESET_CYCLES = 10;
  localparam int          INDEX_BITS   = $clog2(`SOC_MEM_WORDS);
  localparam logic [31:0] MEM_END      = `SOC_MEM_BASE + `SOC_MEM_WORDS * 4;

  logic                   clock;
  logic                   reset;
  logic [31:0]            araddr_0;
  logic                   arvalid_0;
  logic                   arready_0;
  logic [31:0]            rdata_0;
  soc_bus_pkg::bus_resp_t rresp_0;
  logic                   rvalid_0;
  logic                   rready_0;
  logic [31:0]            araddr_1;
  logic                   arvalid_1;
  logic                   arready_1;
  logic [31:0]            rdata_1;
  soc_bus_pkg::bus_resp_t rresp_1;
  logic                   rvalid_1;
  logic                   rready_1;
  logic [31:0]            awaddr_1;
  logic                   awvalid_1;
  logic                   awready_1;
  logic [31:0]            wdata_1;
  logic [3:0]             wstrb_1;
  logic                   wvalid_1;
  logic                   wready_1;
  soc_bus_pkg::bus_resp_t bresp_1;
  logic                   bvalid_1;
  logic                   bready_1;

  logic [31:0]            model_mem [`SOC_MEM_WORDS]; // reference memory.
  logic [31:0]            exp_data_0 [$];
  soc_bus_pkg::bus_resp_t exp_resp_0 [$];
  logic [31:0]            exp_data_1 [$];
  soc_bus_pkg::bus_resp_t exp_resp_1 [$];
  int                     exp_kind_1 [$]; // 0 exact, 1 rising mtime, 2 resp only.
  soc_bus_pkg::bus_resp_t exp_bresp [$];
  int                     errors = 0;
  int                     checks = 0;
  int                     flow_errors = 0;
  time                    r0_done_time = 0;
  time                    r1_rise_time = 0;

  soc_bus_top soc_bus_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic bit in_window(input logic [31:0] addr);
    return (addr >= `SOC_MEM_BASE) && (addr < MEM_END);
  endfunction

  function automatic logic [INDEX_BITS-1:0] word_index(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `SOC_MEM_BASE;
    return offset[INDEX_BITS+1:2];
  endfunction

  // expected {resp, rdata} of a read.
  function automatic logic [33:0] expect_read(input logic [31:0] addr);
    if (in_window(addr)) begin
      return {soc_bus_pkg::RESP_OKAY, model_mem[word_index(addr)]};
    end
    return {soc_bus_pkg::RESP_DECERR, 32'h0};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    return word;
  endfunction

  task automatic read_fetch(input logic [31:0] addr);
    logic [33:0] e;
    int          stall;
    e = expect_read(addr);
    exp_data_0.push_back(e[31:0]);
    exp_resp_0.push_back(soc_bus_pkg::bus_resp_t'(e[33:32]));
    stall = int'($urandom % 4);
    araddr_0  = addr;
    arvalid_0 = 1'b1;
    do @(posedge clock); while (!arready_0);
    #1;
    arvalid_0 = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      #1;
    end
    rready_0 = 1'b1;
    do @(posedge clock); while (!rvalid_0);
    #1;
    rready_0 = 1'b0;
  endtask

  task automatic read_lsu(input logic [31:0] addr, input int kind);
    logic [33:0] e;
    int          stall;
    e = (kind == 0) ? expect_read(addr) : 34'h0;
    exp_kind_1.push_back(kind);
    exp_data_1.push_back(e[31:0]);
    exp_resp_1.push_back(soc_bus_pkg::bus_resp_t'(e[33:32]));
    stall = int'($urandom % 4);
    araddr_1  = addr;
    arvalid_1 = 1'b1;
    do @(posedge clock); while (!arready_1);
    #1;
    arvalid_1 = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      #1;
    end
    rready_1 = 1'b1;
    do @(posedge clock); while (!rvalid_1);
    #1;
    rready_1 = 1'b0;
  endtask

  task automatic write_lsu(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int stall;
    exp_bresp.push_back(in_window(addr) ? soc_bus_pkg::RESP_OKAY : soc_bus_pkg::RESP_DECERR);
    if (in_window(addr)) begin
      model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], data, strb);
    end
    stall = int'($urandom % 4);
    awaddr_1  = addr;
    wdata_1   = data;
    wstrb_1   = strb;
    awvalid_1 = 1'b1;
    wvalid_1  = 1'b1;
    do @(posedge clock); while (!awready_1);
    if (!wready_1) begin
      flow_errors++;
      $display("wready_1 was low at %0t while awready_1 was high", $time);
    end
    #1;
    awvalid_1 = 1'b0;
    wvalid_1  = 1'b0;
    repeat (stall) begin
      @(posedge clock);
      #1;
    end
    bready_1 = 1'b1;
    do @(posedge clock); while (!bvalid_1);
    #1;
    bready_1 = 1'b0;
  endtask

  // checks every response handshake against the expected queues.
  always @(posedge clock) begin : compare_responses
    logic [31:0]            exp_d;
    soc_bus_pkg::bus_resp_t exp_r;
    int                     kind;
    logic [31:0]            last_mtime = 32'h0;
    bit                     have_mtime = 1'b0;
    logic                   rvalid_1_q = 1'b0;
    if (!reset) begin
      if (rvalid_1 && !rvalid_1_q) r1_rise_time = $time;
      if (rvalid_0 && rready_0) begin
        r0_done_time = $time;
        if (exp_data_0.size() == 0) begin
          errors++;
          $display("port 0 gave a response at %0t that nobody asked for", $time);
        end else begin
          exp_d = exp_data_0.pop_front();
          exp_r = exp_resp_0.pop_front();
          checks++;
          if (rdata_0 !== exp_d || rresp_0 !== exp_r) begin
            errors++;
            $display("mismatch at %0t: port 0 read %h resp %0d, expected %h resp %0d",
                     $time, rdata_0, rresp_0, exp_d, exp_r);
          end
        end
      end
      if (rvalid_1 && rready_1) begin
        if (exp_kind_1.size() == 0) begin
          errors++;
          $display("port 1 gave a read response at %0t that nobody asked for", $time);
        end else begin
          kind  = exp_kind_1.pop_front();
          exp_d = exp_data_1.pop_front();
          exp_r = exp_resp_1.pop_front();
          checks++;
          if (kind == 0 && (rdata_1 !== exp_d || rresp_1 !== exp_r)) begin
            errors++;
            $display("mismatch at %0t: port 1 read %h resp %0d, expected %h resp %0d",
                     $time, rdata_1, rresp_1, exp_d, exp_r);
          end
          if (kind != 0 && rresp_1 !== soc_bus_pkg::RESP_OKAY) begin
            errors++;
            $display("mismatch at %0t: mtime read resp %0d, expected OKAY", $time, rresp_1);
          end
          if (kind == 1 && have_mtime && rdata_1 <= last_mtime) begin
            errors++;
            $display("mismatch at %0t: mtime %h not above earlier %h", $time, rdata_1,
                     last_mtime);
          end
          if (kind == 1) begin
            last_mtime = rdata_1;
            have_mtime = 1'b1;
          end
        end
      end
      if (bvalid_1 && bready_1) begin
        if (exp_bresp.size() == 0) begin
          errors++;
          $display("port 1 gave a write response at %0t that nobody asked for", $time);
        end else begin
          exp_r = exp_bresp.pop_front();
          checks++;
          if (bresp_1 !== exp_r) begin
            errors++;
            $display("mismatch at %0t: bresp %0d, expected %0d", $time, bresp_1, exp_r);
          end
        end
      end
    end
    rvalid_1_q = rvalid_1;
  end

  initial begin
    repeat (RESET_CYCLES + 20 * N_TRANS) @(posedge clock);
    $display("timeout: transactions still open after %0d cycles", RESET_CYCLES + 20 * N_TRANS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] fill_addr [N_FILL];
    logic [31:0] addr;
    logic [15:0] strb_set;
    void'($urandom(32'h0592ba92));
    reset     = 1'b1;
    araddr_0  = 32'h0;
    arvalid_0 = 1'b0;
    rready_0  = 1'b0;
    araddr_1  = 32'h0;
    arvalid_1 = 1'b0;
    rready_1  = 1'b0;
    awaddr_1  = 32'h0;
    awvalid_1 = 1'b0;
    wdata_1   = 32'h0;
    wstrb_1   = 4'h0;
    wvalid_1  = 1'b0;
    bready_1  = 1'b0;
    strb_set  = 16'b1011_1000_0110_0001;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;

    // full words written by port 1 and read back by fetch.
    for (int i = 0; i < N_FILL; i++) begin
      fill_addr[i] = `SOC_MEM_BASE + 32'(4 * ($urandom % `SOC_MEM_WORDS));
      write_lsu(fill_addr[i], $urandom, 4'hf);
    end
    for (int i = 0; i < N_FILL; i++) begin
      read_fetch(fill_addr[i]);
    end

    for (int k = 0; k < N_MERGE; k++) begin
      addr = `SOC_MEM_BASE + 32'(k * 68);
      write_lsu(addr, $urandom, 4'hf);
      write_lsu(addr, $urandom, strb_set[4*k +: 4]); // partial merge.
      read_lsu(addr, 0);
    end

    read_lsu(32'h1000_0000, 0);
    write_lsu(MEM_END, 32'hdead_beef, 4'hf); // would alias word 0 if wrapped.
    read_fetch(`SOC_MEM_BASE);

    for (int j = 0; j < 4; j += 2) begin
      fork
        read_fetch(fill_addr[j]);
        read_lsu(fill_addr[j+1], 0);
      join
      if (r1_rise_time <= r0_done_time) begin
        flow_errors++;
        $display("port 1 rvalid rose at %0t, before port 0 finished at %0t",
                 r1_rise_time, r0_done_time);
      end
    end

    read_lsu(`SOC_MTIME_LO, 1);
    repeat (5) @(posedge clock);
    #1;
    read_lsu(`SOC_MTIME_LO, 1);
    read_lsu(`SOC_MTIME_HI, 2);

    repeat (2) @(posedge clock);
    if (exp_data_0.size() != 0 || exp_kind_1.size() != 0 || exp_bresp.size() != 0) begin
      flow_errors++;
      $display("some expected responses never arrived");
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, errors, flow_errors);
    if (errors == 0 && flow_errors == 0 && checks > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* soc_bus_top.f */
+incdir+.
source/soc_bus_pkg.sv
source/clint.sv
source/bus_arbiter.sv
source/sram_slave.sv
source/soc_bus_top.sv
tb/soc_bus_checker.sv
tb/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module soc_bus_tb -f soc_bus_top.f \
  && ./obj_dir/Vsoc_bus_tb 2>&1 | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
